/* mul_cfg.svh */
`ifndef MUL_CFG_SVH
`define MUL_CFG_SVH

// operand width of the core
`define MUL_XLEN 64

// operand width for mulw
`define MUL_WLEN 32

// operands widened by two bits
// room for unsigned 64-bit values and the top radix-4 window
`define MUL_EXT 66

// radix-4 digits to retire, one per iteration
`define MUL_ITER 33
`define MUL_WITER 17

// iteration counter, must hold MUL_ITER
`define MUL_CNT_W 6

`endif

/* mul_pkg.sv */
`default_nettype none

package mul_pkg;

	//******************************************************************
	// controller state
	//******************************************************************
	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_BUSY = 1'b1
	} mul_state_t;

	//******************************************************************
	// radix-4 booth digit
	//******************************************************************
	// bit 2 marks a negative digit
	// low bits give the magnitude, 1 or 2
	typedef enum logic [2:0] {
		BD_ZERO = 3'b000,
		BD_POS1 = 3'b001,
		BD_POS2 = 3'b010,
		BD_NEG1 = 3'b101,
		BD_NEG2 = 3'b110
	} booth_dig_t;

	//******************************************************************
	// sign mode of a request
	//******************************************************************
	// bit 1 for a signed multiplicand, bit 0 for a signed multiplier
	typedef enum logic [1:0] {
		MS_UU = 2'b00,
		MS_US = 2'b01,
		MS_SU = 2'b10,
		MS_SS = 2'b11
	} mul_sign_t;

endpackage

`default_nettype wire

/* booth_sel.sv */
`default_nettype none

`include "mul_cfg.svh"

module booth_sel (
	input  logic [2:0]            window,
	input  logic [`MUL_EXT+1:0]   mcand_ext,
	output logic [`MUL_EXT+1:0]   pp,
	output logic                  neg
);

	import mul_pkg::*;

	localparam int PP_W = `MUL_EXT + 2;

	booth_dig_t            dig;
	logic [PP_W-1:0]       mag;

	//******************************************************************
	// recoding of {b[i+1], b[i], b[i-1]}
	//******************************************************************
	always_comb begin
		dig = BD_ZERO;
		unique case (window)
			3'b000, 3'b111: dig = BD_ZERO;
			3'b001, 3'b010: dig = BD_POS1;
			3'b011:         dig = BD_POS2;
			3'b100:         dig = BD_NEG2;
			3'b101, 3'b110: dig = BD_NEG1;
			default:        dig = BD_ZERO;
		endcase
	end

	// magnitude of the digit applied to the multiplicand
	always_comb begin
		unique case (dig)
			BD_POS1, BD_NEG1: mag = mcand_ext;
			BD_POS2, BD_NEG2: mag = {mcand_ext[PP_W-2:0], 1'b0};
			default:          mag = '0;
		endcase
	end

	// ones complement for negative digits
	assign pp = dig[2] ? ~mag : mag;

	// +1 of the twos complement, taken from the raw window
	// top bit set and not the all-ones window
	assign neg = window[2] & ~(window[1] & window[0]);

	// window decode and digit table must agree on the sign
	always_comb begin
		assert final (!(neg && (dig == BD_ZERO)) && (neg == dig[2]));
	end

endmodule

`default_nettype wire

/* mul_ctrl.sv */
`default_nettype none

`include "mul_cfg.svh"

module mul_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic mul_valid,
	input  logic flush,
	input  logic mulw,
	output logic mul_ready,
	output logic out_valid,
	output logic start,
	output logic step,
	output logic last
);

	import mul_pkg::*;

	// final count for each mode
	localparam logic [`MUL_CNT_W-1:0] LIM_FULL = `MUL_ITER;
	localparam logic [`MUL_CNT_W-1:0] LIM_WORD = `MUL_WITER;

	mul_state_t               state;
	logic [`MUL_CNT_W-1:0]    cnt;
	logic [`MUL_CNT_W-1:0]    cnt_lim;
	logic                     out_valid_q;

	//******************************************************************
	// strobes to the datapath
	//******************************************************************
	assign mul_ready = (state == ST_IDLE);

	// accept when idle, no queue behind it
	assign start = mul_valid & mul_ready;

	// count 0 lets the loaded operands reach the selector
	// iterations run on counts 1 up to the limit
	// a flush kills the iteration in the same cycle
	assign step = (state == ST_BUSY) & (cnt != '0) & ~flush;

	// final digit, result written on the edge that ends it
	assign last = step & (cnt == cnt_lim);

	assign out_valid = out_valid_q;

	//******************************************************************
	// state and iteration counter
	//******************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= ST_IDLE;
			cnt         <= '0;
			cnt_lim     <= LIM_FULL;
			out_valid_q <= 1'b0;
		end else begin
			// one-cycle result pulse
			out_valid_q <= last;
			unique case (state)
				ST_IDLE: begin
					// flush while idle does nothing
					if (start) begin
						state   <= ST_BUSY;
						cnt     <= '0;
						cnt_lim <= mulw ? LIM_WORD : LIM_FULL;
					end
				end
				ST_BUSY: begin
					if (flush || last) begin
						// ready again in the next cycle
						state <= ST_IDLE;
						cnt   <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: begin
					state <= ST_IDLE;
					cnt   <= '0;
				end
			endcase
		end
	end

	//******************************************************************
	// checks
	//******************************************************************
	// result strobe never stretches
	a_out_pulse: assert property (@(posedge clk) disable iff (rst)
		out_valid |=> !out_valid);

	// accept loads a clean count and holds off the next request
	a_no_restart: assert property (@(posedge clk) disable iff (rst)
		start |=> !mul_ready && (cnt == '0));

	// iterations only after at least one busy cycle
	a_step_busy: assert property (@(posedge clk) disable iff (rst)
		step |-> (state == ST_BUSY) && $past(state == ST_BUSY));

endmodule

`default_nettype wire

/* mul_datapath.sv */
`default_nettype none

`include "mul_cfg.svh"

module mul_datapath (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  start,
	input  logic                  step,
	input  logic                  last,
	input  logic                  mulw,
	input  mul_pkg::mul_sign_t    mul_signed,
	input  logic [`MUL_XLEN-1:0]  mulcand,
	input  logic [`MUL_XLEN-1:0]  muler,
	input  logic [`MUL_EXT+1:0]   pp,
	input  logic                  neg,
	output logic [2:0]            window,
	output logic [`MUL_EXT+1:0]   mcand_ext,
	output logic [`MUL_XLEN-1:0]  result_hi,
	output logic [`MUL_XLEN-1:0]  result_lo
);

	// partial product width, 2x multiplicand plus sign
	localparam int PP_W  = `MUL_EXT + 2;
	// upper partial sum and the bits shifted out below it
	localparam int ACC_W = PP_W + `MUL_EXT;
	// word product sits this far up after the short run
	localparam int WOFF  = `MUL_EXT - 2 * `MUL_WITER;

	logic [`MUL_EXT-1:0]   mc_q;
	logic [`MUL_EXT:0]     mer_q;
	logic [ACC_W-1:0]      acc_q;
	logic                  mulw_q;

	logic [PP_W-1:0]       pp_sum;
	logic [ACC_W-1:0]      acc_nxt;
	logic [`MUL_WLEN-1:0]  wlo;

	//******************************************************************
	// operand extension
	//******************************************************************
	// word mode keeps the low half only
	// fill bit is the operand sign when signed, else zero
	function automatic logic [`MUL_EXT-1:0] ext_op(
		input logic [`MUL_XLEN-1:0] op,
		input logic                 sgn,
		input logic                 word
	);
		logic                  fill;
		logic [`MUL_XLEN-1:0]  src;
		fill = sgn & (word ? op[`MUL_WLEN-1] : op[`MUL_XLEN-1]);
		src  = word ? {{(`MUL_XLEN-`MUL_WLEN){fill}}, op[`MUL_WLEN-1:0]} : op;
		return {{(`MUL_EXT-`MUL_XLEN){fill}}, src};
	endfunction

	// multiplicand widened once more for the selector
	assign mcand_ext = {{(PP_W-`MUL_EXT){mc_q[`MUL_EXT-1]}}, mc_q};

	// lowest window, bit -1 is the zero padded in at load
	assign window = mer_q[2:0];

	//******************************************************************
	// accumulate and shift
	//******************************************************************
	// pp plus neg into the top of the accumulator
	assign pp_sum = acc_q[ACC_W-1 -: PP_W] + pp + PP_W'(neg);

	// arithmetic shift right by one digit
	assign acc_nxt = {{2{pp_sum[PP_W-1]}}, pp_sum, acc_q[`MUL_EXT-1:2]};

	// low word of the product in word mode
	assign wlo = acc_nxt[WOFF +: `MUL_WLEN];

	always_ff @(posedge clk) begin
		if (start) begin
			mc_q   <= ext_op(mulcand, mul_signed[1], mulw);
			mer_q  <= {ext_op(muler, mul_signed[0], mulw), 1'b0};
			acc_q  <= '0;
			mulw_q <= mulw;
		end else if (step) begin
			acc_q <= acc_nxt;
			// next window, sign kept at the top
			mer_q <= {{2{mer_q[`MUL_EXT]}}, mer_q[`MUL_EXT:2]};
		end
	end

	//******************************************************************
	// result formatting
	//******************************************************************
	always_ff @(posedge clk) begin
		if (rst) begin
			result_hi <= '0;
			result_lo <= '0;
		end else if (last) begin
			if (mulw_q) begin
				// mulw returns the sign-extended low word
				result_lo <= {{(`MUL_XLEN-`MUL_WLEN){wlo[`MUL_WLEN-1]}}, wlo};
				result_hi <= {`MUL_XLEN{wlo[`MUL_WLEN-1]}};
			end else begin
				result_hi <= acc_nxt[2*`MUL_XLEN-1:`MUL_XLEN];
				result_lo <= acc_nxt[`MUL_XLEN-1:0];
			end
		end
	end

	// results only change on a real iteration from the controller
	a_last_step: assert property (@(posedge clk) disable iff (rst)
		last |-> step && !start);

endmodule

`default_nettype wire

/* mul_unit.sv */
`default_nettype none

`include "mul_cfg.svh"

module mul_unit (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  mul_valid,
	input  logic                  flush,
	input  logic                  mulw,
	input  mul_pkg::mul_sign_t    mul_signed,
	input  logic [`MUL_XLEN-1:0]  mulcand,
	input  logic [`MUL_XLEN-1:0]  muler,
	output logic                  mul_ready,
	output logic                  out_valid,
	output logic [`MUL_XLEN-1:0]  result_hi,
	output logic [`MUL_XLEN-1:0]  result_lo
);

	// controller strobes
	logic                  start;
	logic                  step;
	logic                  last;

	// selector loop
	logic [2:0]            window;
	logic [`MUL_EXT+1:0]   mcand_ext;
	logic [`MUL_EXT+1:0]   pp;
	logic                  neg;

	//******************************************************************
	// control, only block that sees flush
	//******************************************************************
	mul_ctrl ctrl_i (
		.clk       (clk),
		.rst       (rst),
		.mul_valid (mul_valid),
		.flush     (flush),
		.mulw      (mulw),
		.mul_ready (mul_ready),
		.out_valid (out_valid),
		.start     (start),
		.step      (step),
		.last      (last)
	);

	//******************************************************************
	// operands, accumulator and result
	//******************************************************************
	mul_datapath dp_i (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.step       (step),
		.last       (last),
		.mulw       (mulw),
		.mul_signed (mul_signed),
		.mulcand    (mulcand),
		.muler      (muler),
		.pp         (pp),
		.neg        (neg),
		.window     (window),
		.mcand_ext  (mcand_ext),
		.result_hi  (result_hi),
		.result_lo  (result_lo)
	);

	// combinational booth digit select
	booth_sel sel_i (
		.window    (window),
		.mcand_ext (mcand_ext),
		.pp        (pp),
		.neg       (neg)
	);

endmodule

`default_nettype wire

/* mul_checker.sv */
`default_nettype none

`include "mul_cfg.svh"

module mul_checker (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  mul_valid,
	input  logic                  flush,
	input  logic                  mulw,
	input  logic [1:0]            mul_signed,
	input  logic [`MUL_XLEN-1:0]  mulcand,
	input  logic [`MUL_XLEN-1:0]  muler,
	input  logic                  mul_ready,
	input  logic                  out_valid,
	input  logic [`MUL_XLEN-1:0]  result_hi,
	input  logic [`MUL_XLEN-1:0]  result_lo,
	output int                    err_cnt,
	output int                    done_cnt,
	output int                    flush_cnt
);

	timeunit 1ns;
	timeprecision 1ps;

	// accept edge to rising out_valid
	localparam int LAT_FULL = 34;
	localparam int LAT_WORD = 18;

	int                    test_id;
	int                    cyc;
	int                    lat;
	logic                  pending;
	logic                  ready_due;
	logic                  in_reset;
	logic                  ready_bad;
	logic                  test_bad;
	logic [`MUL_XLEN-1:0]  exp_hi;
	logic [`MUL_XLEN-1:0]  exp_lo;
	logic [1:0]            cap_s;
	logic                  cap_w;

	//******************************************************************
	// reference product
	//******************************************************************
	// each operand widened by its own mode bit, product mod 2^128
	// word mode only keeps the low 32 bits, sign repeated upward
	task automatic expected_product(
		input  logic [63:0] a,
		input  logic [63:0] b,
		input  logic [1:0]  s,
		input  logic        w,
		output logic [63:0] hi,
		output logic [63:0] lo
	);
		logic [127:0] a_w;
		logic [127:0] b_w;
		logic [127:0] p;
		logic [31:0]  p32;
		a_w = s[1] ? {{64{a[63]}}, a} : {64'd0, a};
		b_w = s[0] ? {{64{b[63]}}, b} : {64'd0, b};
		p   = a_w * b_w;
		p32 = a[31:0] * b[31:0];
		if (w) begin
			lo = {{32{p32[31]}}, p32};
			hi = {64{p32[31]}};
		end else begin
			hi = p[127:64];
			lo = p[63:0];
		end
	endtask

	// one line per wrong value
	task automatic value_mismatch(input string name, input logic [63:0] exp, input logic [63:0] got);
		$display("[FAIL] %0d ns %s expected %h got %h", $time, name, exp, got);
		err_cnt++;
		test_bad = 1'b1;
	endtask

	//******************************************************************
	// port monitor
	//******************************************************************
	// all reads happen on the edge, before the DUT updates
	always @(posedge clk) begin
		if (rst) begin
			err_cnt   = 0;
			done_cnt  = 0;
			flush_cnt = 0;
			test_id   = 0;
			cyc       = 0;
			pending   = 1'b0;
			ready_due = 1'b0;
			in_reset  = 1'b1;
		end else begin
			// idle state right out of reset
			if (in_reset) begin
				in_reset = 1'b0;
				if (mul_ready !== 1'b1)
					value_mismatch("mul_ready", 64'd1, {63'd0, mul_ready});
				if (out_valid !== 1'b0)
					value_mismatch("out_valid", 64'd0, {63'd0, out_valid});
			end
			// one edge after the flush edge
			if (ready_due) begin
				ready_due = 1'b0;
				if (mul_ready !== 1'b1)
					value_mismatch("mul_ready", 64'd1, {63'd0, mul_ready});
				$display("test %0d flushed, %s", test_id, test_bad ? "failed" : "ok");
			end
			if (pending)
				cyc++;
			if (out_valid === 1'b1) begin
				if (!pending) begin
					$display("%0d ns: out_valid pulsed with no operation in flight", $time);
					err_cnt++;
				end else begin
					pending = 1'b0;
					if (cyc - 1 != lat) begin
						$display("[FAIL] %0d ns out_valid latency expected %0d got %0d",
							$time, lat, cyc - 1);
						err_cnt++;
						test_bad = 1'b1;
					end
					// ready again in the result cycle
					if (mul_ready !== 1'b1)
						value_mismatch("mul_ready", 64'd1, {63'd0, mul_ready});
					if (result_hi !== exp_hi)
						value_mismatch("result_hi", exp_hi, result_hi);
					if (result_lo !== exp_lo)
						value_mismatch("result_lo", exp_lo, result_lo);
					done_cnt++;
					$display("test %0d %s mode %b: %s", test_id, cap_w ? "word" : "full",
						cap_s, test_bad ? "failed" : "ok");
				end
			end else if (pending) begin
				if (cyc >= lat + 1) begin
					$display("test %0d: no out_valid within %0d cycles of accept", test_id, lat);
					err_cnt++;
					pending = 1'b0;
				end else if (mul_ready !== 1'b0 && !ready_bad) begin
					// busy span, report once per test
					ready_bad = 1'b1;
					value_mismatch("mul_ready", 64'd0, {63'd0, mul_ready});
				end
			end
			// abort of the operation in flight
			if (pending && flush === 1'b1) begin
				pending   = 1'b0;
				ready_due = 1'b1;
				flush_cnt++;
			end
			if (mul_valid === 1'b1 && mul_ready === 1'b1) begin
				if (pending) begin
					$display("%0d ns: request accepted while test %0d still busy", $time, test_id);
					err_cnt++;
				end
				test_id++;
				pending   = 1'b1;
				ready_bad = 1'b0;
				test_bad  = 1'b0;
				cyc       = 0;
				cap_s     = mul_signed;
				cap_w     = mulw;
				lat       = mulw ? LAT_WORD : LAT_FULL;
				expected_product(mulcand, muler, mul_signed, mulw, exp_hi, exp_lo);
			end
		end
	end

endmodule

`default_nettype wire

/* tb_mul_unit.sv */
`default_nettype none

`include "mul_cfg.svh"

module tb_mul_unit;

	timeunit 1ns;
	timeprecision 1ps;

	import mul_pkg::*;

	localparam int N_DIR  = 18;
	localparam int N_RND  = 8;
	localparam int N_ROWS = N_DIR + N_RND;
	localparam logic [63:0] ONES = {64{1'b1}};
	localparam logic [63:0] MINV = {1'b1, 63'd0};

	logic                  clk;
	logic                  rst;
	logic                  mul_valid;
	logic                  flush;
	logic                  mulw;
	mul_sign_t             mul_signed;
	logic [`MUL_XLEN-1:0]  mulcand;
	logic [`MUL_XLEN-1:0]  muler;
	logic                  mul_ready;
	logic                  out_valid;
	logic [`MUL_XLEN-1:0]  result_hi;
	logic [`MUL_XLEN-1:0]  result_lo;

	int                    err_cnt;
	int                    done_cnt;
	int                    flush_cnt;

	//******************************************************************
	// stimulus table
	//******************************************************************
	logic [63:0]           t_mcand [N_ROWS];
	logic [63:0]           t_mer   [N_ROWS];
	logic [1:0]            t_sign  [N_ROWS];
	logic                  t_w     [N_ROWS];
	int                    t_flush [N_ROWS];
	logic                  t_poke  [N_ROWS];
	logic [31:0]           lfsr;

	always #2 clk = ~clk;

	mul_unit dut_i (
		.clk        (clk),
		.rst        (rst),
		.mul_valid  (mul_valid),
		.flush      (flush),
		.mulw       (mulw),
		.mul_signed (mul_signed),
		.mulcand    (mulcand),
		.muler      (muler),
		.mul_ready  (mul_ready),
		.out_valid  (out_valid),
		.result_hi  (result_hi),
		.result_lo  (result_lo)
	);

	mul_checker chk_i (
		.clk (clk), .rst (rst), .mul_valid (mul_valid), .flush (flush),
		.mulw (mulw), .mul_signed (mul_signed), .mulcand (mulcand), .muler (muler),
		.mul_ready (mul_ready), .out_valid (out_valid),
		.result_hi (result_hi), .result_lo (result_lo),
		.err_cnt (err_cnt), .done_cnt (done_cnt), .flush_cnt (flush_cnt)
	);

	// galois form, taps for x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	task automatic take_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			v    = {v[62:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic set_row(input int i, input logic [63:0] a, input logic [63:0] b,
		input logic [1:0] s, input logic w, input int fl, input logic pk);
		t_mcand[i] = a;
		t_mer[i]   = b;
		t_sign[i]  = s;
		t_w[i]     = w;
		t_flush[i] = fl;
		t_poke[i]  = pk;
	endtask

	task automatic fill_table();
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] s;
		logic [63:0] w;
		set_row(0, 64'd0, 64'h1234, 2'b11, 1'b0, 0, 1'b0);
		set_row(1, 64'd1, 64'd1, 2'b00, 1'b0, 0, 1'b0);
		set_row(2, ONES, ONES, 2'b00, 1'b0, 0, 1'b0);
		set_row(3, ONES, ONES, 2'b11, 1'b0, 0, 1'b0);
		set_row(4, ONES, ONES, 2'b10, 1'b0, 0, 1'b0);
		set_row(5, ONES, ONES, 2'b01, 1'b0, 0, 1'b0);
		set_row(6, MINV, MINV, 2'b11, 1'b0, 0, 1'b0);
		set_row(7, MINV, ONES, 2'b10, 1'b0, 0, 1'b0);
		set_row(8, MINV, MINV, 2'b00, 1'b0, 0, 1'b0);
		set_row(9, 64'h123456789abcdef0, 64'h0fedcba987654321, 2'b01, 1'b0, 0, 1'b0);
		// word mode, upper operand bits must not matter
		set_row(10, 64'hffffffff80000000, 64'h000000007fffffff, 2'b11, 1'b1, 0, 1'b0);
		set_row(11, 64'h00000000ffffffff, 64'd2, 2'b00, 1'b1, 0, 1'b0);
		set_row(12, 64'h5555aaaa00000003, 64'hdeadbeef80000001, 2'b10, 1'b1, 0, 1'b0);
		// aborts and ignored requests while busy
		set_row(13, 64'h0123456789abcdef, 64'hfedcba9876543210, 2'b11, 1'b0, 5, 1'b0);
		set_row(14, 64'h0123456789abcdef, 64'hfedcba9876543210, 2'b00, 1'b0, 0, 1'b1);
		set_row(15, 64'h00000000c0ffee00, 64'h00000000beef0001, 2'b11, 1'b1, 10, 1'b0);
		set_row(16, MINV, 64'd3, 2'b10, 1'b0, 20, 1'b0);
		set_row(17, 64'h00000000f0f0f0f0, 64'h000000000f0f0f0f, 2'b01, 1'b1, 0, 1'b1);
		lfsr = 32'h6552f8e4;
		for (int i = N_DIR; i < N_ROWS; i++) begin
			take_bits(64, a);
			take_bits(64, b);
			take_bits(2, s);
			take_bits(1, w);
			set_row(i, a, b, s[1:0], w[0], 0, 1'b0);
		end
	endtask

	//******************************************************************
	// stimulus loop
	//******************************************************************
	initial begin
		int n_flush;
		int n_miss;
		clk        = 1'b0;
		rst        = 1'b1;
		mul_valid  = 1'b0;
		flush      = 1'b0;
		mulw       = 1'b0;
		mul_signed = MS_UU;
		mulcand    = '0;
		muler      = '0;
		n_flush    = 0;
		n_miss     = 0;
		fill_table();
		repeat (2) @(posedge clk);
		#1 rst = 1'b0;
		@(posedge clk);
		for (int i = 0; i < N_ROWS; i++) begin
			while (!mul_ready)
				@(posedge clk);
			#1;
			mul_valid  = 1'b1;
			mulcand    = t_mcand[i];
			muler      = t_mer[i];
			mul_signed = mul_sign_t'(t_sign[i]);
			mulw       = t_w[i];
			@(posedge clk);
			#1 mul_valid = 1'b0;
			if (t_poke[i]) begin
				// different request mid-operation, must be dropped
				repeat (2) @(posedge clk);
				#1;
				mul_valid  = 1'b1;
				mulcand    = ~t_mcand[i];
				muler      = t_mer[i] ^ 64'h00ff00ff00ff00ff;
				mul_signed = mul_sign_t'(~t_sign[i]);
				mulw       = ~t_w[i];
				@(posedge clk);
				#1 mul_valid = 1'b0;
			end
			if (t_flush[i] != 0) begin
				n_flush++;
				repeat (t_flush[i]) @(posedge clk);
				#1 flush = 1'b1;
				@(posedge clk);
				#1 flush = 1'b0;
			end
			@(posedge clk);
		end
		while (!mul_ready)
			@(posedge clk);
		repeat (3) @(posedge clk);
		if (done_cnt != N_ROWS - n_flush || flush_cnt != n_flush) begin
			$display("expected %0d results and %0d aborts, saw %0d results and %0d aborts",
				N_ROWS - n_flush, n_flush, done_cnt, flush_cnt);
			n_miss = 1;
		end
		$display("rows %0d, results %0d, aborts %0d, errors %0d",
			N_ROWS, done_cnt, flush_cnt, err_cnt + n_miss);
		if (err_cnt + n_miss == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// generous bound, a row needs at most about 40 cycles
	initial begin
		#((N_ROWS * 40 + 50) * 4);
		$display("timeout: the run did not finish in %0d cycles", N_ROWS * 40 + 50);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
mul_pkg.sv
booth_sel.sv
mul_ctrl.sv
mul_datapath.sv
mul_unit.sv
mul_checker.sv
tb_mul_unit.sv
